/* rv_core.f */
source/rv_pkg.sv
source/rv_extend.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_datapath.sv
source/rv_decoder.sv
source/rv_core.sv
verification/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - source/rv_pkg.sv
      - source/rv_extend.sv
      - source/rv_regfile.sv
      - source/rv_alu.sv
      - source/rv_datapath.sv
      - source/rv_decoder.sv
      - source/rv_core.sv
  - target: test
    files:
      - verification/rv_core_tb.sv

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int PERIOD         = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int PROG_WORDS     = 64;                          // program fills imem
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_WORDS + 20;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [31:0] pc;
    logic [31:0] data_addr;
    logic [31:0] write_data;
    logic        mem_we;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    integer      seed = 70420;
    int          pos;                // next free program word
    logic [31:0] halt_pc;            // final self loop

    // shadow isa model state and its expectations for the current instruction
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [64];
    logic        m_store;
    logic [31:0] m_addr;
    logic [31:0] m_wdata;
    logic        m_we;
    logic [4:0]  m_rd;
    logic [31:0] m_wb;
    logic [31:0] m_next;
    logic        m_flow;             // branch or jump

    rv_core i_rv_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_we     (mem_we)
    );

    always #(PERIOD / 2) clk = ~clk;

    assign instr     = imem[pc[7:2]];          // combinational fetch
    assign read_data = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[data_addr[7:2]] <= write_data;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], rv_pkg::OPC_STORE};   // sw only
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'($unsigned($random(seed)) % 8);   // x0..x7, x0 included on purpose
    endfunction

    function automatic logic [11:0] rnd_off();
        return 12'(($unsigned($random(seed)) % 64) * 4);   // word address inside dmem
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[pos] = word;
        pos++;
    endtask

    task automatic build_program();
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [11:0] off;
        pos = 0;
        emit(enc_s(rnd_off(), 5'd0, 5'd0));             // store sits at pc 0 during reset
        emit(enc_u(rv_pkg::OPC_LUI, 5'd1, 20'($random(seed))));
        emit(enc_s(rnd_off(), 5'd1, 5'd0));
        emit(enc_u(rv_pkg::OPC_AUIPC, 5'd2, 20'($random(seed))));
        emit(enc_s(rnd_off(), 5'd2, 5'd0));
        for (int r = 3; r < 8; r++) begin
            emit(enc_i(3'b000, 5'(r), 5'd0, 12'($random(seed)), rv_pkg::OPC_OP_IMM));
        end
        for (int k = 0; k < 10; k++) begin              // eight funct3 plus sub and sra
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
            alt = (k >= 8);
            rd  = rnd_reg();
            emit(enc_r(f3, alt, rd, rnd_reg(), rnd_reg()));
            emit(enc_s(rnd_off(), rd, 5'd0));
        end
        off = 12'd0;
        for (int k = 0; k < 9; k++) begin               // eight funct3 plus srai
            f3 = (k < 8) ? 3'(k) : 3'b101;
            if ((f3 == 3'b001) || (f3 == 3'b101)) begin
                imm = {1'b0, (k == 8), 5'd0, 5'($random(seed))};
            end else begin
                imm = 12'($random(seed));
            end
            rd  = rnd_reg();
            off = rnd_off();
            emit(enc_i(f3, rd, rnd_reg(), imm, rv_pkg::OPC_OP_IMM));
            emit(enc_s(off, rd, 5'd0));
        end
        rd = rnd_reg();
        emit(enc_i(3'b010, rd, 5'd0, off, rv_pkg::OPC_LOAD));   // reads the word just stored
        emit(enc_s(rnd_off(), rd, 5'd0));
        for (int k = 0; k < 6; k++) begin               // beq bne blt bge bltu bgeu, skip one
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            emit(enc_b(f3, rnd_reg(), rnd_reg(), 13'd8));
        end
        emit(enc_i(3'b000, 5'd3, 5'd3, 12'd1, rv_pkg::OPC_OP_IMM));
        emit(enc_j(5'd5, 21'd16));                      // over both link stores and the halt
        emit(enc_s(rnd_off(), 5'd5, 5'd0));             // jal link
        emit(enc_s(rnd_off(), 5'd6, 5'd0));             // jalr link
        halt_pc = 32'(pos * 4);
        emit(enc_j(5'd0, 21'd0));                       // halt loop
        emit(enc_u(rv_pkg::OPC_AUIPC, 5'd7, 20'd0));
        emit(enc_i(3'b000, 5'd6, 5'd7, 12'(-11), rv_pkg::OPC_JALR));   // odd, bit 0 dropped
        emit(enc_j(5'd0, 21'd0));                       // trap, never reached
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? (x - y) : (x + y);
            3'b001:  r = x << y[4:0];
            3'b010:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  r = (x < y) ? 32'd1 : 32'd0;
            3'b100:  r = x ^ y;
            3'b101: begin
                if (alt) begin
                    r = $signed(x) >>> y[4:0];   // sign fill
                end else begin
                    r = x >> y[4:0];
                end
            end
            3'b110:  r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    // expectations for the instruction at m_pc
    task automatic model_eval();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] ld_addr;
        logic [2:0]  f3;
        logic        take;
        ins     = imem[m_pc[7:2]];
        f3      = ins[14:12];
        a       = m_regs[ins[19:15]];
        b       = m_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        ld_addr = a + imm_i;
        m_store = 1'b0;
        m_addr  = a + imm_s;
        m_wdata = b;
        m_we    = 1'b0;
        m_rd    = ins[11:7];
        m_wb    = 32'd0;
        m_next  = m_pc + 32'd4;
        m_flow  = 1'b0;
        take    = 1'b0;
        case (ins[6:0])
            rv_pkg::OPC_OP: begin
                m_we = 1'b1;
                m_wb = alu_ref(f3, ins[30], a, b);
            end
            rv_pkg::OPC_OP_IMM: begin
                m_we = 1'b1;
                m_wb = alu_ref(f3, ins[30] && (f3 == 3'b101), a, imm_i);   // shamt in imm[4:0]
            end
            rv_pkg::OPC_LOAD: begin
                m_we = (f3 == 3'b010);
                m_wb = m_dmem[ld_addr[7:2]];
            end
            rv_pkg::OPC_STORE: m_store = (f3 == 3'b010);
            rv_pkg::OPC_BRANCH: begin
                m_flow = 1'b1;
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    m_next = m_pc + imm_b;
                end
            end
            rv_pkg::OPC_JAL: begin
                m_flow = 1'b1;
                m_we   = 1'b1;
                m_wb   = m_pc + 32'd4;
                m_next = m_pc + imm_j;
            end
            rv_pkg::OPC_JALR: begin
                if (f3 == 3'b000) begin
                    m_flow = 1'b1;
                    m_we   = 1'b1;
                    m_wb   = m_pc + 32'd4;
                    m_next = (a + imm_i) & ~32'd1;
                end
            end
            rv_pkg::OPC_LUI: begin
                m_we = 1'b1;
                m_wb = {ins[31:12], 12'd0};
            end
            rv_pkg::OPC_AUIPC: begin
                m_we = 1'b1;
                m_wb = m_pc + {ins[31:12], 12'd0};
            end
            default: ;   // unknown opcode is a no-op
        endcase
    endtask

    task automatic model_step();
        if (m_store) begin
            m_dmem[m_addr[7:2]] = m_wdata;
        end
        if (m_we && (m_rd != 5'd0)) begin
            m_regs[m_rd] = m_wb;
        end
        m_pc = m_next;
        model_eval();
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            model_step();   // retires alongside the dut
        end
    end

    a_reset_no_store: assert property (@(posedge clk) !rst_n |-> !mem_we)
        else report_mismatch("mem_we high during reset");

    a_first_fetch: assert property (
        @(posedge clk) $rose(rst_n) |-> (pc == 32'd0)
    ) else report_mismatch($sformatf("first fetch at pc 0x%08h", $sampled(pc)));

    a_pc_tracks: assert property (@(posedge clk) disable iff (!rst_n) pc == m_pc)
        else report_mismatch($sformatf("pc 0x%08h, model pc 0x%08h",
                                       $sampled(pc), $sampled(m_pc)));

    a_store_strobe: assert property (@(posedge clk) disable iff (!rst_n) mem_we == m_store)
        else report_mismatch($sformatf("mem_we %0b, model store %0b at pc 0x%08h",
                                       $sampled(mem_we), $sampled(m_store), $sampled(pc)));

    a_store_payload: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_we |-> (data_addr == m_addr) && (write_data == m_wdata)
    ) else report_mismatch($sformatf("sw addr 0x%08h data 0x%08h, model 0x%08h 0x%08h",
                                     $sampled(data_addr), $sampled(write_data),
                                     $sampled(m_addr), $sampled(m_wdata)));

    a_flow_target: assert property (
        @(posedge clk) disable iff (!rst_n) m_flow |=> (pc == $past(m_next))
    ) else report_mismatch($sformatf("jump or branch landed at 0x%08h", $sampled(pc)));

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        abort_run("watchdog timeout: the core never reached its final loop");
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        build_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i]   = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0f0f;   // distinct per word
            m_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        m_pc = 32'd0;
        model_eval();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        while (pc != halt_pc) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);   // let the halt loop be checked too
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [31:0] instr,        // fetched word at pc
    input  wire  [31:0] read_data,    // word at data_addr, same cycle
    output logic [31:0] pc,
    output logic [31:0] data_addr,
    output logic [31:0] write_data,
    output logic        mem_we
);
    rv_pkg::ctrl_t      ctrl;
    rv_pkg::alu_flags_t flags;
    logic [31:0]        alu_out;

    rv_decoder i_rv_decoder (
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    rv_datapath i_rv_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_out    (alu_out),
        .write_data (write_data),
        .flags      (flags)
    );

    assign data_addr = alu_out;               // lw / sw effective address
    assign mem_we    = ctrl.mem_we & rst_n;   // no stores during reset

endmodule

`default_nettype wire

/* source/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire                      [31:0] instr,
    input  wire rv_pkg::alu_flags_t         flags,
    output rv_pkg::ctrl_t                   ctrl
);
    logic [2:0] funct3;
    logic       alt;          // funct7 bit 5, sub / arithmetic shift
    logic       is_shift;
    logic       take;         // branch condition holds

    assign funct3   = instr[14:12];
    assign alt      = instr[30];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt_op);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt_op ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt_op ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // flags come from rs1 - rs2
    always_comb begin
        case (funct3)
            3'b000:  take = flags.zero;                      // beq
            3'b001:  take = ~flags.zero;                     // bne
            3'b100:  take = flags.neg ^ flags.overflow;      // blt
            3'b101:  take = ~(flags.neg ^ flags.overflow);   // bge
            3'b110:  take = ~flags.carry;                    // bltu
            3'b111:  take = flags.carry;                     // bgeu
            default: take = 1'b0;                            // reserved, falls through
        endcase
    end

    always_comb begin
        ctrl.reg_we  = 1'b0;   // no-op unless decoded below
        ctrl.mem_we  = 1'b0;
        ctrl.imm_src = rv_pkg::IMM_SRC_ITYPE;
        ctrl.alu_op  = rv_pkg::ALU_ADD;
        ctrl.alu_src = rv_pkg::ALU_SRC_REG_IMM;
        ctrl.res_src = rv_pkg::RES_SRC_ALU_OUT;
        ctrl.pc_src  = rv_pkg::PC_SRC_PLUS_4;
        case (rv_pkg::opcode_e'(instr[6:0]))
            rv_pkg::OPC_OP: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = rv_pkg::ALU_SRC_REG_REG;
                ctrl.alu_op  = arith_op(funct3, alt);
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_op  = arith_op(funct3, alt && (funct3 == 3'b101));   // no subi
                ctrl.imm_src = is_shift ? rv_pkg::IMM_SRC_ITYPE2 : rv_pkg::IMM_SRC_ITYPE;
            end
            rv_pkg::OPC_LOAD: begin
                ctrl.reg_we  = (funct3 == 3'b010);   // lw only
                ctrl.res_src = rv_pkg::RES_SRC_MEM;
            end
            rv_pkg::OPC_STORE: begin
                ctrl.mem_we  = (funct3 == 3'b010);   // sw only
                ctrl.imm_src = rv_pkg::IMM_SRC_STYPE;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.imm_src = rv_pkg::IMM_SRC_BTYPE;
                ctrl.alu_src = rv_pkg::ALU_SRC_REG_REG;
                ctrl.alu_op  = rv_pkg::ALU_SUB;
                ctrl.pc_src  = take ? rv_pkg::PC_SRC_PLUS_OFF : rv_pkg::PC_SRC_PLUS_4;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.reg_we  = 1'b1;
                ctrl.imm_src = rv_pkg::IMM_SRC_JTYPE;
                ctrl.res_src = rv_pkg::RES_SRC_PC_PLUS_4;
                ctrl.pc_src  = rv_pkg::PC_SRC_PLUS_OFF;
            end
            rv_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.reg_we  = 1'b1;
                    ctrl.res_src = rv_pkg::RES_SRC_PC_PLUS_4;
                    ctrl.pc_src  = rv_pkg::PC_SRC_REG_PLUS_OFF;
                end
            end
            rv_pkg::OPC_LUI: begin
                ctrl.reg_we  = 1'b1;
                ctrl.imm_src = rv_pkg::IMM_SRC_UTYPE;
                ctrl.res_src = rv_pkg::RES_SRC_EXT_IMM;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.reg_we  = 1'b1;
                ctrl.imm_src = rv_pkg::IMM_SRC_UTYPE;
                ctrl.alu_src = rv_pkg::ALU_SRC_PC_IMM;
            end
            default: ;   // illegal opcode, plain pc + 4
        endcase
    end

    // a store never writes back, over every opcode and funct3 pattern
    always_comb begin
        a_no_we_overlap: assert final (!(ctrl.reg_we && ctrl.mem_we))
            else $error("reg_we and mem_we both set for instr 0x%08h", instr);
    end

endmodule

`default_nettype wire

/* source/rv_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_datapath (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                  [31:0] instr,
    input  wire                  [31:0] read_data,
    input  wire rv_pkg::ctrl_t          ctrl,
    output logic                 [31:0] pc,
    output logic                 [31:0] alu_out,
    output logic                 [31:0] write_data,
    output rv_pkg::alu_flags_t          flags
);
    logic [31:0] ext_imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_plus_off;
    logic [31:0] reg_plus_off;
    logic [31:0] pc_next;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] wb_data;

    // next pc
    assign pc_plus_4    = pc + 32'd4;
    assign pc_plus_off  = pc + ext_imm;                    // branch / jal target
    assign reg_plus_off = (rs1_data + ext_imm) & ~32'd1;   // jalr clears bit 0

    always_comb begin
        case (ctrl.pc_src)
            rv_pkg::PC_SRC_PLUS_OFF:     pc_next = pc_plus_off;
            rv_pkg::PC_SRC_REG_PLUS_OFF: pc_next = reg_plus_off;
            default:                     pc_next = pc_plus_4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= 32'd0;   // boot from word 0
        end else begin
            pc <= pc_next;
        end
    end

    // operand select
    always_comb begin
        case (ctrl.alu_src)
            rv_pkg::ALU_SRC_REG_REG: begin
                src_a = rs1_data;
                src_b = rs2_data;
            end
            rv_pkg::ALU_SRC_PC_IMM: begin
                src_a = pc;        // auipc
                src_b = ext_imm;
            end
            default: begin
                src_a = rs1_data;
                src_b = ext_imm;
            end
        endcase
    end

    // write-back select
    always_comb begin
        case (ctrl.res_src)
            rv_pkg::RES_SRC_PC_PLUS_4: wb_data = pc_plus_4;   // link address
            rv_pkg::RES_SRC_EXT_IMM:   wb_data = ext_imm;
            rv_pkg::RES_SRC_MEM:       wb_data = read_data;
            default:                   wb_data = alu_out;
        endcase
    end

    assign write_data = rs2_data;   // sw stores rs2

    rv_extend i_rv_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .ext_imm (ext_imm)
    );

    rv_regfile i_rv_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .rd_addr  (instr[11:7]),
        .wr_data  (wb_data),
        .we       (ctrl.reg_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu i_rv_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (ctrl.alu_op),
        .result (alu_out),
        .flags  (flags)
    );

    // targets from the decoder and extender must keep fetch on word boundaries
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else $error("pc 0x%08h not word aligned", pc);

endmodule

`default_nettype wire

/* source/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire                    [31:0] a,
    input  wire                    [31:0] b,
    input  wire rv_pkg::alu_op_e          op,
    output logic                   [31:0] result,
    output rv_pkg::alu_flags_t            flags
);
    logic        sub;     // adder runs as a + ~b + 1
    logic [31:0] b_in;
    logic [32:0] sum;     // bit 32 is carry out
    logic [4:0]  shamt;

    assign sub   = (op == rv_pkg::ALU_SUB) || (op == rv_pkg::ALU_SLT) ||
                   (op == rv_pkg::ALU_SLTU);
    assign b_in  = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_in} + {32'd0, sub};
    assign shamt = b[4:0];   // only low five bits shift

    assign flags.zero     = (sum[31:0] == 32'd0);
    assign flags.neg      = sum[31];
    assign flags.carry    = sum[32];                                   // no borrow on subtract
    assign flags.overflow = (a[31] == b_in[31]) && (sum[31] != a[31]); // signs in equal, out flips

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD,
            rv_pkg::ALU_SUB:    result = sum[31:0];
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SLT:    result = {31'd0, flags.neg ^ flags.overflow};   // signed less
            rv_pkg::ALU_SLTU:   result = {31'd0, ~flags.carry};                 // borrow
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  rs1_addr,
    input  wire  [4:0]  rs2_addr,
    input  wire  [4:0]  rd_addr,
    input  wire  [31:0] wr_data,
    input  wire         we,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);
    logic [31:0] regs [32];   // x0 slot only cleared by reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0] <= 32'd0;
        end else if (we && (rd_addr != 5'd0)) begin   // no writes while in reset
            regs[rd_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];   // x0 held by the write gate
    assign rs2_data = regs[rs2_addr];

    // x0 stays zero on both ports even right after a write to rd = 0
    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((rs1_addr == 5'd0) |-> (rs1_data == 32'd0)) and
        ((rs2_addr == 5'd0) |-> (rs2_data == 32'd0))
    ) else $error("register x0 read back nonzero");

endmodule

`default_nettype wire

/* source/rv_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_extend (
    input  wire                  [31:0] instr,
    input  wire rv_pkg::imm_src_e       imm_src,
    output logic                 [31:0] ext_imm
);
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [31:0] u_imm;
    logic [31:0] shamt_imm;

    assign i_imm     = {{20{instr[31]}}, instr[31:20]};
    assign s_imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};       // split field
    assign b_imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};                                 // halfword offset
    assign j_imm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
    assign u_imm     = {instr[31:12], 12'd0};                               // low bits zero
    assign shamt_imm = {27'd0, instr[24:20]};                               // no sign, funct7 dropped

    always_comb begin
        case (imm_src)
            rv_pkg::IMM_SRC_ITYPE:  ext_imm = i_imm;
            rv_pkg::IMM_SRC_STYPE:  ext_imm = s_imm;
            rv_pkg::IMM_SRC_BTYPE:  ext_imm = b_imm;
            rv_pkg::IMM_SRC_JTYPE:  ext_imm = j_imm;
            rv_pkg::IMM_SRC_UTYPE:  ext_imm = u_imm;
            rv_pkg::IMM_SRC_ITYPE2: ext_imm = shamt_imm;
            default:                ext_imm = 32'd0;   // unused encodings
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // major opcodes of the rv32i subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_SRC_ITYPE  = 3'd0,   // loads, jalr, alu immediates
        IMM_SRC_STYPE  = 3'd1,   // stores
        IMM_SRC_BTYPE  = 3'd2,   // branch offset, bit 0 zero
        IMM_SRC_JTYPE  = 3'd3,   // jal offset
        IMM_SRC_UTYPE  = 3'd4,   // lui / auipc upper 20 bits
        IMM_SRC_ITYPE2 = 3'd5    // zero-extended shamt
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_REG_IMM,         // rs1 op imm
        ALU_SRC_REG_REG,         // rs1 op rs2
        ALU_SRC_PC_IMM           // pc op imm, auipc
    } alu_src_e;

    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_PC_PLUS_4,       // link value for jal / jalr
        RES_SRC_EXT_IMM,         // lui
        RES_SRC_MEM              // lw
    } res_src_e;

    typedef enum logic [1:0] {
        PC_SRC_PLUS_4,
        PC_SRC_PLUS_OFF,         // taken branch, jal
        PC_SRC_REG_PLUS_OFF      // jalr, bit 0 cleared
    } pc_src_e;

    typedef struct packed {
        logic zero;
        logic neg;
        logic carry;             // set means a >= b unsigned on subtract
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        imm_src_e imm_src;
        alu_op_e  alu_op;
        alu_src_e alu_src;
        res_src_e res_src;
        pc_src_e  pc_src;
    } ctrl_t;

endpackage

`default_nettype wire
